//--- design/mem_cfg.svh
/*
 * Data memory stage configuration: widths, RAM depth, port count
 * and the inclusive base/bound pairs of the read and write maps.
 */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// datapath widths.
`define MEM_ADDR_WIDTH      12
`define MEM_DATA_WIDTH      32

`define MEM_RAM_DEPTH       1024    // words of data RAM.
`define MEM_IO_PORTS        8       // input ports and output ports, each.

// read map. I/O input ports sit right above the RAM.
`define MEM_RD_RAM_BASE     12'h000
`define MEM_RD_RAM_BOUND    12'h3FF
`define MEM_RD_IO_BASE      12'h400
`define MEM_RD_IO_BOUND     12'h407

// write map. I/O output ports live in their own window at 0x800.
`define MEM_WR_RAM_BASE     12'h000
`define MEM_WR_RAM_BOUND    12'h3FF
`define MEM_WR_IO_BASE      12'h800
`define MEM_WR_IO_BOUND     12'h807

`endif

//--- design/mem_types_pkg.sv
/*
 * Datapath types of the data memory stage.
 */
`default_nettype none

`include "mem_cfg.svh"

package mem_types_pkg;

    // one data word as seen by the pipeline, the RAM and the I/O ports.
    typedef logic [`MEM_DATA_WIDTH-1:0] word_t;

    // address used by both the read map and the write map.
    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

    typedef logic [$clog2(`MEM_RAM_DEPTH)-1:0] ram_addr_t;  // word index into the RAM.

    typedef logic [$clog2(`MEM_IO_PORTS)-1:0] port_idx_t;   // selects one I/O port.

endpackage

`default_nettype wire

//--- design/mem_map_pkg.sv
/*
 * Memory map definitions. Names the range an enabled access decoded to.
 */
`default_nettype none

package mem_map_pkg;

    // region_none covers both disabled accesses and unmapped addresses,
    // so anything tagged with it is simply dropped.
    typedef enum logic [1:0] {
        region_none = 2'd0,
        region_ram  = 2'd1,     // data RAM window.
        region_io   = 2'd2      // I/O port window of the map in use.
    } region_e;

endpackage

`default_nettype wire

//--- design/mem_addressing.sv
/*
 * Read and write address decoding for the data memory stage. Gates requests,
 * maps them onto the RAM or the I/O bank, and returns the read data.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module mem_addressing (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     read_ior,
    input  logic                     read_cancel,
    input  mem_types_pkg::addr_t     read_addr,
    input  logic                     write_ior,
    input  logic                     write_cancel,
    input  mem_types_pkg::addr_t     write_addr,
    input  mem_types_pkg::word_t     write_data,
    output logic                     ram_wr_en,
    output mem_types_pkg::ram_addr_t ram_wr_addr,
    output mem_types_pkg::word_t     ram_wr_data,
    output logic                     ram_rd_en,
    output mem_types_pkg::ram_addr_t ram_rd_addr,
    input  mem_types_pkg::word_t     ram_rd_data,
    output logic                     io_wr_en,
    output mem_types_pkg::port_idx_t io_wr_idx,
    output mem_types_pkg::word_t     io_wr_data,
    output logic                     io_rd_en,
    output mem_types_pkg::port_idx_t io_rd_idx,
    input  mem_types_pkg::word_t     io_rd_data,
    output mem_types_pkg::word_t     read_data,
    output logic                     read_valid
);

    logic                 read_ok;
    logic                 write_ok;
    mem_map_pkg::region_e rd_region;
    mem_map_pkg::region_e wr_region;
    mem_map_pkg::region_e rd_region_q;

    // Both maps have the same shape, a RAM window and an I/O window with
    // inclusive bounds. Only the constants differ between read and write.
    function automatic mem_map_pkg::region_e decode_region(
        input logic                 en,
        input mem_types_pkg::addr_t addr,
        input mem_types_pkg::addr_t ram_base,
        input mem_types_pkg::addr_t ram_bound,
        input mem_types_pkg::addr_t io_base,
        input mem_types_pkg::addr_t io_bound
    );
        mem_map_pkg::region_e region;
        region = mem_map_pkg::region_none;
        if (en && addr >= ram_base && addr <= ram_bound) begin
            region = mem_map_pkg::region_ram;
        end else if (en && addr >= io_base && addr <= io_bound) begin
            region = mem_map_pkg::region_io;
        end
        return region;
    endfunction

    assign read_ok  = read_ior && !read_cancel;     // annulled reads are ignored.
    assign write_ok = write_ior && !write_cancel;

    assign rd_region = decode_region(read_ok, read_addr, `MEM_RD_RAM_BASE, `MEM_RD_RAM_BOUND,
                                     `MEM_RD_IO_BASE, `MEM_RD_IO_BOUND);
    assign wr_region = decode_region(write_ok, write_addr, `MEM_WR_RAM_BASE, `MEM_WR_RAM_BOUND,
                                     `MEM_WR_IO_BASE, `MEM_WR_IO_BOUND);

    // Indices are offsets from the base of the window that was hit.
    assign ram_wr_en   = (wr_region == mem_map_pkg::region_ram);
    assign ram_wr_addr = mem_types_pkg::ram_addr_t'(write_addr - `MEM_WR_RAM_BASE);
    assign ram_wr_data = write_data;
    assign ram_rd_en   = (rd_region == mem_map_pkg::region_ram);
    assign ram_rd_addr = mem_types_pkg::ram_addr_t'(read_addr - `MEM_RD_RAM_BASE);

    assign io_wr_en    = (wr_region == mem_map_pkg::region_io);
    assign io_wr_idx   = mem_types_pkg::port_idx_t'(write_addr - `MEM_WR_IO_BASE);
    assign io_wr_data  = write_data;
    assign io_rd_en    = (rd_region == mem_map_pkg::region_io);
    assign io_rd_idx   = mem_types_pkg::port_idx_t'(read_addr - `MEM_RD_IO_BASE);

    // the region travels alongside the one-cycle RAM and port read latency.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_region_q <= mem_map_pkg::region_none;
        end else begin
            rd_region_q <= rd_region;
        end
    end

    always_comb begin
        case (rd_region_q)
            mem_map_pkg::region_ram: read_data = ram_rd_data;
            mem_map_pkg::region_io:  read_data = io_rd_data;
            default:                 read_data = '0;    // nothing was read.
        endcase
    end

    assign read_valid = (rd_region_q != mem_map_pkg::region_none);

endmodule

`default_nettype wire

//--- design/data_ram.sv
/*
 * Data RAM with one write port and one registered read port.
 * A colliding read returns the word held before the write.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module data_ram (
    input  logic                     clk,
    input  logic                     wr_en,
    input  mem_types_pkg::ram_addr_t wr_addr,
    input  mem_types_pkg::word_t     wr_data,
    input  logic                     rd_en,
    input  mem_types_pkg::ram_addr_t rd_addr,
    output mem_types_pkg::word_t     rd_data
);

    mem_types_pkg::word_t mem [`MEM_RAM_DEPTH];     // contents are undefined until written.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // The read samples the array before the write of the same edge lands,
    // which gives read-before-write on a collision.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];    // holds its value between reads.
        end
    end

endmodule

`default_nettype wire

//--- design/io_port_bank.sv
/*
 * I/O port bank. Output registers with a one-cycle write strobe per port,
 * and a registered read of the input ports.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module io_port_bank (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         wr_en,
    input  mem_types_pkg::port_idx_t                     wr_idx,
    input  mem_types_pkg::word_t                         wr_data,
    input  logic                                         rd_en,
    input  mem_types_pkg::port_idx_t                     rd_idx,
    output mem_types_pkg::word_t                         rd_data,
    input  mem_types_pkg::word_t [`MEM_IO_PORTS-1:0]     io_in,
    output mem_types_pkg::word_t [`MEM_IO_PORTS-1:0]     io_out,
    output logic                 [`MEM_IO_PORTS-1:0]     io_wr_strobe
);

    // Output registers. Only the addressed port changes on a write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_out <= '0;
        end else if (wr_en) begin
            io_out[wr_idx] <= wr_data;
        end
    end

    // The strobe is high in the cycle where io_out shows the new word,
    // so a consumer can latch the value on the strobe alone.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_wr_strobe <= '0;
        end else begin
            for (int i = 0; i < `MEM_IO_PORTS; i++) begin
                io_wr_strobe[i] <= wr_en && (wr_idx == mem_types_pkg::port_idx_t'(i));
            end
        end
    end

    // input ports are sampled at the issue edge.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= io_in[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- design/data_mem_top.sv
/*
 * Data memory access stage. Joins the address decoder, the data RAM
 * and the I/O port bank.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module data_mem_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     read_ior,
    input  logic                                     read_cancel,
    input  mem_types_pkg::addr_t                     read_addr,
    input  logic                                     write_ior,
    input  logic                                     write_cancel,
    input  mem_types_pkg::addr_t                     write_addr,
    input  mem_types_pkg::word_t                     write_data,
    input  mem_types_pkg::word_t [`MEM_IO_PORTS-1:0] io_in,
    output mem_types_pkg::word_t                     read_data,
    output logic                                     read_valid,
    output mem_types_pkg::word_t [`MEM_IO_PORTS-1:0] io_out,
    output logic                 [`MEM_IO_PORTS-1:0] io_wr_strobe
);

    logic                     ram_wr_en;
    mem_types_pkg::ram_addr_t ram_wr_addr;
    mem_types_pkg::word_t     ram_wr_data;
    logic                     ram_rd_en;
    mem_types_pkg::ram_addr_t ram_rd_addr;
    mem_types_pkg::word_t     ram_rd_data;

    logic                     io_wr_en;
    mem_types_pkg::port_idx_t io_wr_idx;
    mem_types_pkg::word_t     io_wr_data;
    logic                     io_rd_en;
    mem_types_pkg::port_idx_t io_rd_idx;
    mem_types_pkg::word_t     io_rd_data;

    mem_addressing u_addressing (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_ior     (read_ior),
        .read_cancel  (read_cancel),
        .read_addr    (read_addr),
        .write_ior    (write_ior),
        .write_cancel (write_cancel),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_addr  (ram_wr_addr),
        .ram_wr_data  (ram_wr_data),
        .ram_rd_en    (ram_rd_en),
        .ram_rd_addr  (ram_rd_addr),
        .ram_rd_data  (ram_rd_data),
        .io_wr_en     (io_wr_en),
        .io_wr_idx    (io_wr_idx),
        .io_wr_data   (io_wr_data),
        .io_rd_en     (io_rd_en),
        .io_rd_idx    (io_rd_idx),
        .io_rd_data   (io_rd_data),
        .read_data    (read_data),
        .read_valid   (read_valid)
    );

    data_ram u_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_en   (ram_rd_en),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    io_port_bank u_io (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (io_wr_en),
        .wr_idx       (io_wr_idx),
        .wr_data      (io_wr_data),
        .rd_en        (io_rd_en),
        .rd_idx       (io_rd_idx),
        .rd_data      (io_rd_data),
        .io_in        (io_in),
        .io_out       (io_out),
        .io_wr_strobe (io_wr_strobe)
    );

endmodule

`default_nettype wire

//--- verif/data_mem_assert.sv
/*
 * Port-level assertions for the data memory stage, bound into the top level.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module data_mem_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     read_ior,
    input logic                     read_cancel,
    input mem_types_pkg::addr_t     read_addr,
    input logic                     read_valid,
    input logic [`MEM_IO_PORTS-1:0] io_wr_strobe
);

    int   failures = 0;     // read back by the testbench at the end.
    logic read_hit;

    function automatic logic in_range(input mem_types_pkg::addr_t a,
                                      input mem_types_pkg::addr_t lo,
                                      input mem_types_pkg::addr_t hi);
        return (a >= lo) && (a <= hi);
    endfunction

    // an enabled read that lands in either window of the read map.
    assign read_hit = read_ior && !read_cancel
                      && (in_range(read_addr, `MEM_RD_RAM_BASE, `MEM_RD_RAM_BOUND)
                          || in_range(read_addr, `MEM_RD_IO_BASE, `MEM_RD_IO_BOUND));

    valid_needs_reads: assert property (@(posedge clk) disable iff (!rst_n)
        read_valid && $past(read_valid) |-> $past(read_hit) && $past(read_hit, 2))
        else begin
            failures++;
            $error("read_valid stayed high without two issued reads before it");
        end

    strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(io_wr_strobe))
        else begin
            failures++;
            $error("more than one io_wr_strobe bit is high");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !read_valid && io_wr_strobe == '0)
        else begin
            failures++;
            $error("read_valid or io_wr_strobe is high during reset");
        end

endmodule

bind data_mem_top data_mem_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .read_ior     (read_ior),
    .read_cancel  (read_cancel),
    .read_addr    (read_addr),
    .read_valid   (read_valid),
    .io_wr_strobe (io_wr_strobe)
);

`default_nettype wire

//--- verif/tb_data_mem.sv
/*
 * Testbench for the data memory stage. Random reads and writes from an xorshift
 * source are checked cycle by cycle against a model of the RAM and I/O ports.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module tb_data_mem;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 5;
    localparam int N_PAIRS        = 16;
    localparam int N_CANCEL       = 40;
    localparam int N_MAPS         = 4 * `MEM_IO_PORTS;
    localparam int N_UNMAPPED     = 32;
    localparam int N_COLLIDE      = 8;
    localparam int N_MIX          = 2000;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + 3 * N_PAIRS + N_CANCEL + N_MAPS
                                    + N_UNMAPPED + 2 * N_COLLIDE + N_MIX;
    localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 100;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     read_ior;
    logic                                     read_cancel;
    mem_types_pkg::addr_t                     read_addr;
    logic                                     write_ior;
    logic                                     write_cancel;
    mem_types_pkg::addr_t                     write_addr;
    mem_types_pkg::word_t                     write_data;
    mem_types_pkg::word_t [`MEM_IO_PORTS-1:0] io_in;
    mem_types_pkg::word_t                     read_data;
    logic                                     read_valid;
    mem_types_pkg::word_t [`MEM_IO_PORTS-1:0] io_out;
    logic                 [`MEM_IO_PORTS-1:0] io_wr_strobe;

    bit [31:0]            rng_state = 32'h483248e5;
    mem_types_pkg::word_t model_ram [`MEM_RAM_DEPTH];
    bit                   ram_known [`MEM_RAM_DEPTH];   // set once a RAM word was written.
    mem_types_pkg::word_t model_io_out [`MEM_IO_PORTS];
    mem_types_pkg::addr_t written_q [$];
    int                   checks;
    int                   mismatches;

    data_mem_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_ior     (read_ior),
        .read_cancel  (read_cancel),
        .read_addr    (read_addr),
        .write_ior    (write_ior),
        .write_cancel (write_cancel),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .io_in        (io_in),
        .read_data    (read_data),
        .read_valid   (read_valid),
        .io_out       (io_out),
        .io_wr_strobe (io_wr_strobe)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic bit [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    function automatic mem_types_pkg::word_t rand_word();
        return mem_types_pkg::word_t'(next_rand());
    endfunction

    function automatic bit in_window(input mem_types_pkg::addr_t a,
                                     input mem_types_pkg::addr_t lo,
                                     input mem_types_pkg::addr_t hi);
        return (a >= lo) && (a <= hi);
    endfunction

    // a word from 0x408..0x7FF or 0x808..0xFFF, outside both maps.
    function automatic mem_types_pkg::addr_t unmapped_addr();
        if (next_rand() & 32'h1) begin
            return mem_types_pkg::addr_t'(32'h408 + rand_below(32'h3F8));
        end
        return mem_types_pkg::addr_t'(32'h808 + rand_below(32'h7F8));
    endfunction

    // Biased so RAM, both I/O windows and unmapped space all show up.
    function automatic mem_types_pkg::addr_t pick_addr();
        int kind;
        kind = rand_below(8);
        case (kind)
            0, 1:    return mem_types_pkg::addr_t'(rand_below(32));   // hot window, reads hit data.
            2, 3:    return mem_types_pkg::addr_t'(rand_below(`MEM_RAM_DEPTH));
            4:       return mem_types_pkg::addr_t'(32'h400 + rand_below(`MEM_IO_PORTS));
            5:       return mem_types_pkg::addr_t'(32'h800 + rand_below(`MEM_IO_PORTS));
            default: return unmapped_addr();
        endcase
    endfunction

    task automatic check_word(input string what, input mem_types_pkg::word_t expected,
                              input mem_types_pkg::word_t actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("Mismatch in %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input bit expected, input bit actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("Mismatch in %s: expected %0b, actual %0b", what, expected, actual);
        end
    endtask

    // Entered 2 ns after a rising edge. Drives one cycle of requests, lets the
    // model see them at the next edge and checks the outputs 1 ns later.
    task automatic run_cycle(input string test_name,
                             input bit rd_ior, input bit rd_cancel,
                             input mem_types_pkg::addr_t rd_addr,
                             input bit wr_ior, input bit wr_cancel,
                             input mem_types_pkg::addr_t wr_addr,
                             input mem_types_pkg::word_t wr_data);
        bit                           exp_valid;
        bit                           data_known;
        mem_types_pkg::word_t         exp_data;
        logic [`MEM_IO_PORTS-1:0]     exp_strobe;
        int                           idx;
        read_ior     = rd_ior;
        read_cancel  = rd_cancel;
        read_addr    = rd_addr;
        write_ior    = wr_ior;
        write_cancel = wr_cancel;
        write_addr   = wr_addr;
        write_data   = wr_data;
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            io_in[p] = rand_word();
        end
        @(posedge clk);
        exp_valid  = 1'b0;
        data_known = 1'b0;
        exp_data   = '0;
        exp_strobe = '0;
        if (rd_ior && !rd_cancel && in_window(rd_addr, `MEM_RD_RAM_BASE, `MEM_RD_RAM_BOUND)) begin
            idx        = int'(rd_addr) - int'(`MEM_RD_RAM_BASE);
            exp_valid  = 1'b1;
            data_known = ram_known[idx];
            exp_data   = model_ram[idx];    // old word, the write below lands afterwards.
        end else if (rd_ior && !rd_cancel
                     && in_window(rd_addr, `MEM_RD_IO_BASE, `MEM_RD_IO_BOUND)) begin
            idx        = int'(rd_addr) - int'(`MEM_RD_IO_BASE);
            exp_valid  = 1'b1;
            data_known = 1'b1;
            exp_data   = io_in[idx];
        end
        if (wr_ior && !wr_cancel && in_window(wr_addr, `MEM_WR_RAM_BASE, `MEM_WR_RAM_BOUND)) begin
            idx            = int'(wr_addr) - int'(`MEM_WR_RAM_BASE);
            model_ram[idx] = wr_data;
            ram_known[idx] = 1'b1;
        end else if (wr_ior && !wr_cancel
                     && in_window(wr_addr, `MEM_WR_IO_BASE, `MEM_WR_IO_BOUND)) begin
            idx               = int'(wr_addr) - int'(`MEM_WR_IO_BASE);
            model_io_out[idx] = wr_data;
            exp_strobe[idx]   = 1'b1;
        end
        #1;
        check_flag({test_name, " read_valid"}, exp_valid, read_valid);
        if (exp_valid && data_known) begin
            check_word({test_name, " read_data"}, exp_data, read_data);
        end
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            check_word($sformatf("%s io_out[%0d]", test_name, p), model_io_out[p], io_out[p]);
            check_flag($sformatf("%s io_wr_strobe[%0d]", test_name, p), exp_strobe[p],
                       io_wr_strobe[p]);
        end
        #1;
    endtask

    task automatic test_ram_write_read();
        mem_types_pkg::addr_t a;
        for (int i = 0; i < N_PAIRS; i++) begin
            a = mem_types_pkg::addr_t'(rand_below(`MEM_RAM_DEPTH));
            written_q.push_back(a);
            run_cycle("ram_write_read", 1'b0, 1'b0, '0, 1'b1, 1'b0, a, rand_word());
        end
        foreach (written_q[i]) begin
            run_cycle("ram_write_read", 1'b1, 1'b0, written_q[i], 1'b0, 1'b0, '0, '0);
        end
    endtask

    // Every access here is either annulled or never issued. Half the writes aim at
    // words already written, so the read-back below catches any that leaked.
    task automatic test_cancel();
        bit [31:0]            r;
        mem_types_pkg::addr_t wa;
        for (int i = 0; i < N_CANCEL; i++) begin
            r  = next_rand();
            wa = r[4] ? written_q[rand_below(written_q.size())] : pick_addr();
            run_cycle("cancel", r[0], r[0] ? 1'b1 : r[1], pick_addr(),
                      r[2], r[2] ? 1'b1 : r[3], wa, rand_word());
        end
        foreach (written_q[i]) begin
            run_cycle("cancel", 1'b1, 1'b0, written_q[i], 1'b0, 1'b0, '0, '0);
        end
    endtask

    task automatic test_separate_maps();
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            run_cycle("separate_maps", 1'b0, 1'b0, '0, 1'b1, 1'b0,
                      mem_types_pkg::addr_t'(32'h800 + p), rand_word());
        end
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            run_cycle("separate_maps", 1'b0, 1'b0, '0, 1'b1, 1'b0,
                      mem_types_pkg::addr_t'(32'h400 + p), rand_word());
        end
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            run_cycle("separate_maps", 1'b1, 1'b0, mem_types_pkg::addr_t'(32'h400 + p),
                      1'b0, 1'b0, '0, '0);
        end
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            run_cycle("separate_maps", 1'b1, 1'b0, mem_types_pkg::addr_t'(32'h800 + p),
                      1'b0, 1'b0, '0, '0);
        end
    endtask

    task automatic test_unmapped();
        for (int i = 0; i < N_UNMAPPED; i++) begin
            run_cycle("unmapped", 1'b1, 1'b0, unmapped_addr(), 1'b1, 1'b0, unmapped_addr(),
                      rand_word());
        end
    endtask

    task automatic test_collision();
        mem_types_pkg::addr_t a;
        for (int i = 0; i < N_COLLIDE; i++) begin
            a = written_q[i % written_q.size()];
            run_cycle("collision", 1'b1, 1'b0, a, 1'b1, 1'b0, a, rand_word());
            run_cycle("collision", 1'b1, 1'b0, a, 1'b0, 1'b0, '0, '0);  // now the new word.
        end
    endtask

    task automatic test_back_to_back();
        bit [31:0] r;
        for (int i = 0; i < N_MIX; i++) begin
            r = next_rand();
            run_cycle("back_to_back", r[1:0] != 2'd0, r[4:2] == 3'd0, pick_addr(),
                      r[6:5] != 2'd0, r[9:7] == 3'd0, pick_addr(), rand_word());
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b1;    // falls at 1 ns, so the reset sees a real edge.
        read_ior     = 1'b0;
        read_cancel  = 1'b0;
        read_addr    = '0;
        write_ior    = 1'b0;
        write_cancel = 1'b0;
        write_addr   = '0;
        write_data   = '0;
        io_in        = '0;
        checks       = 0;
        mismatches   = 0;
        for (int p = 0; p < `MEM_IO_PORTS; p++) begin
            model_io_out[p] = '0;
        end
        #1 rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
        test_ram_write_read();
        test_cancel();
        test_separate_maps();
        test_unmapped();
        test_collision();
        test_back_to_back();
        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, mismatches, UUT.u_assert.failures);
        if (mismatches == 0 && UUT.u_assert.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/mem_types_pkg.sv
design/mem_map_pkg.sv
design/mem_addressing.sv
design/data_ram.sv
design/io_port_bank.sv
design/data_mem_top.sv
verif/data_mem_assert.sv
verif/tb_data_mem.sv

//--- Makefile
# Verilator build and run of the data memory stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_data_mem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) design/mem_cfg.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
